/* common/trap_pkg.sv */
// Shared widths, CSR map and cause codes for the machine-mode trap block
// RV32 only; user mode and vendor CSRs are not modelled
package trap_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int XLEN       = 32;               // Data and address width
    localparam int CSR_ADDR_W = 12;               // CSR address width
    localparam int CAUSE_W    = 5;                // Trap cause code width

    // ------------------------------------------------------------------
    // Machine CSR addresses
    // ------------------------------------------------------------------
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL    = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP      = 12'h344;

    // Interrupt causes, also their bit index in mie and mip
    localparam logic [CAUSE_W-1:0] IRQ_MSI = 5'd3;  // Software
    localparam logic [CAUSE_W-1:0] IRQ_MTI = 5'd7;  // Timer
    localparam logic [CAUSE_W-1:0] IRQ_MEI = 5'd11; // External

    localparam int MSTATUS_MIE_BIT  = 3;          // Global enable
    localparam int MSTATUS_MPIE_BIT = 7;          // Enable before trap

    localparam logic [XLEN-1:0] MTVEC_RESET         = 32'h0000_0100; // Direct mode
    localparam logic [1:0]      MTVEC_MODE_VECTORED = 2'd1;

    // mtvec seen as a raw CSR word or as base and mode fields
    typedef union packed {
        logic [XLEN-1:0] raw;                     // CSR access view
        struct packed {
            logic [XLEN-3:0] base;                // Word-aligned base
            logic [1:0]      mode;                // 0 direct, 1 vectored
        } f;
    } mtvec_word_u;

endpackage

/* csr/csr_regs.sv */
// Machine CSR file with read, write, set and clear access
// Reads are combinational, writes land on the next edge
// A trap or MRET update beats a CSR write to the same register
module csr_regs (
    input  logic                            g_clk,
    input  logic                            i_arst_n,
    input  logic                            i_csr_en,
    input  logic                            i_csr_wr,
    input  logic                            i_csr_set,
    input  logic                            i_csr_clr,
    input  logic [trap_pkg::CSR_ADDR_W-1:0] i_csr_addr,
    input  logic [trap_pkg::XLEN-1:0]       i_csr_wdata,
    output logic [trap_pkg::XLEN-1:0]       o_csr_rdata,
    output logic                            o_csr_error,
    input  logic                            i_int_sw,
    input  logic                            i_int_ext,
    input  logic                            i_int_ti,
    input  logic                            i_trap_take,
    input  logic                            i_trap_is_int,
    input  logic [trap_pkg::CAUSE_W-1:0]    i_trap_cause,
    input  logic [trap_pkg::XLEN-1:0]       i_trap_pc,
    input  logic [trap_pkg::XLEN-1:0]       i_trap_mtval,
    input  logic                            i_mret_take,
    output logic                            o_mstatus_mie,
    output logic                            o_mie_meie,
    output logic                            o_mie_mtie,
    output logic                            o_mie_msie,
    output logic                            o_mip_meip,
    output logic                            o_mip_mtip,
    output logic                            o_mip_msip,
    output trap_pkg::mtvec_word_u           o_mtvec,
    output logic [trap_pkg::XLEN-1:0]       o_mepc
);
    import trap_pkg::*;

    logic            mstatus_mpie;                // MIE before last trap
    logic [XLEN-1:0] mscratch, mcause, mtval;
    logic [XLEN-1:0] mstatus_word, mie_word, mip_word;
    logic [XLEN-1:0] w_wval;                      // Value after wr/set/clr
    mtvec_word_u     w_mtvec_nxt;
    logic            w_known;                     // Address decodes
    logic            w_wr_any;                    // Any modifying access

    // ------------------------------------------------------------------
    // Read decode
    // ------------------------------------------------------------------
    always_comb begin
        mstatus_word                   = '0;
        mstatus_word[MSTATUS_MIE_BIT]  = o_mstatus_mie;
        mstatus_word[MSTATUS_MPIE_BIT] = mstatus_mpie;
        mie_word                       = '0;
        mie_word[IRQ_MEI]              = o_mie_meie;
        mie_word[IRQ_MTI]              = o_mie_mtie;
        mie_word[IRQ_MSI]              = o_mie_msie;
        mip_word                       = '0;
        mip_word[IRQ_MEI]              = o_mip_meip;
        mip_word[IRQ_MTI]              = o_mip_mtip;
        mip_word[IRQ_MSI]              = o_mip_msip;
    end

    always_comb begin
        w_known     = 1'b1;
        o_csr_rdata = '0;
        case (i_csr_addr)
            CSR_MSTATUS:  o_csr_rdata = mstatus_word;
            CSR_MIE:      o_csr_rdata = mie_word;
            CSR_MTVEC:    o_csr_rdata = o_mtvec.raw;
            CSR_MSCRATCH: o_csr_rdata = mscratch;
            CSR_MEPC:     o_csr_rdata = o_mepc;
            CSR_MCAUSE:   o_csr_rdata = mcause;
            CSR_MTVAL:    o_csr_rdata = mtval;
            CSR_MIP:      o_csr_rdata = mip_word;
            default:      w_known     = 1'b0;      // Reads as zero
        endcase
    end

    assign w_wr_any    = i_csr_en && (i_csr_wr || i_csr_set || i_csr_clr);
    assign o_csr_error = i_csr_en && (!w_known || (w_wr_any && i_csr_addr == CSR_MIP));

    // Write takes priority over set, set over clear
    assign w_wval = i_csr_wr  ? i_csr_wdata :
                    i_csr_set ? (o_csr_rdata | i_csr_wdata) :
                                (o_csr_rdata & ~i_csr_wdata);

    always_comb begin
        w_mtvec_nxt.raw       = w_wval;
        w_mtvec_nxt.f.mode[1] = 1'b0;             // Only direct or vectored
    end

    // ------------------------------------------------------------------
    // Register updates
    // ------------------------------------------------------------------
    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mstatus_mie <= 1'b0;
            mstatus_mpie  <= 1'b0;
        end else if (i_trap_take) begin
            mstatus_mpie  <= o_mstatus_mie;       // Stack the enable
            o_mstatus_mie <= 1'b0;
        end else if (i_mret_take) begin
            o_mstatus_mie <= mstatus_mpie;        // Unstack
            mstatus_mpie  <= 1'b1;
        end else if (w_wr_any && i_csr_addr == CSR_MSTATUS) begin
            o_mstatus_mie <= w_wval[MSTATUS_MIE_BIT];
            mstatus_mpie  <= w_wval[MSTATUS_MPIE_BIT];
        end
    end

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mie_meie  <= 1'b0;
            o_mie_mtie  <= 1'b0;
            o_mie_msie  <= 1'b0;
            o_mtvec.raw <= MTVEC_RESET;
            mscratch    <= '0;
        end else if (w_wr_any) begin
            if (i_csr_addr == CSR_MIE) begin
                o_mie_meie <= w_wval[IRQ_MEI];
                o_mie_mtie <= w_wval[IRQ_MTI];
                o_mie_msie <= w_wval[IRQ_MSI];
            end
            if (i_csr_addr == CSR_MTVEC) begin
                o_mtvec <= w_mtvec_nxt;
            end
            if (i_csr_addr == CSR_MSCRATCH) begin
                mscratch <= w_wval;
            end
        end
    end

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mepc <= '0;
            mcause <= '0;
            mtval  <= '0;
        end else if (i_trap_take) begin
            o_mepc <= {i_trap_pc[XLEN-1:2], 2'b00}; // Word aligned
            mcause <= {i_trap_is_int, {(XLEN-1-CAUSE_W){1'b0}}, i_trap_cause};
            mtval  <= i_trap_mtval;
        end else if (w_wr_any) begin
            if (i_csr_addr == CSR_MEPC) begin
                o_mepc <= {w_wval[XLEN-1:2], 2'b00};
            end
            if (i_csr_addr == CSR_MCAUSE) begin
                mcause <= w_wval;
            end
            if (i_csr_addr == CSR_MTVAL) begin
                mtval <= w_wval;
            end
        end
    end

    // Pending bits sample the interrupt lines, one cycle late
    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mip_meip <= 1'b0;
            o_mip_mtip <= 1'b0;
            o_mip_msip <= 1'b0;
        end else begin
            o_mip_meip <= i_int_ext;
            o_mip_mtip <= i_int_ti;
            o_mip_msip <= i_int_sw;
        end
    end

endmodule

/* csr/int_prio.sv */
// Interrupt masking, priority and vector target, purely combinational
// Priority is external, then software, then timer
module int_prio (
    input  logic                          i_mstatus_mie,
    input  logic                          i_mie_meie,
    input  logic                          i_mie_mtie,
    input  logic                          i_mie_msie,
    input  logic                          i_mip_meip,
    input  logic                          i_mip_mtip,
    input  logic                          i_mip_msip,
    input  trap_pkg::mtvec_word_u         i_mtvec,
    output logic                          o_int_request,
    output logic [trap_pkg::CAUSE_W-1:0]  o_int_cause,
    output logic [trap_pkg::XLEN-1:0]     o_int_tvec,
    output logic                          o_int_pending
);
    import trap_pkg::*;

    logic            w_ext, w_tim, w_sw;         // Pending and enabled
    logic            w_any;
    logic [XLEN-1:0] w_base;                     // Byte address of base
    logic [XLEN-1:0] w_offs;                     // 4 x cause

    assign w_ext = i_mip_meip && i_mie_meie;
    assign w_tim = i_mip_mtip && i_mie_mtie;
    assign w_sw  = i_mip_msip && i_mie_msie;
    assign w_any = w_ext || w_tim || w_sw;

    assign o_int_request = w_any &&  i_mstatus_mie;
    assign o_int_pending = w_any && !i_mstatus_mie; // Held off by MIE

    always_comb begin
        if (w_ext) begin
            o_int_cause = IRQ_MEI;
        end else if (w_sw) begin
            o_int_cause = IRQ_MSI;
        end else begin
            o_int_cause = IRQ_MTI;               // Also the idle value
        end
    end

    // ------------------------------------------------------------------
    // Vector target
    // ------------------------------------------------------------------
    assign w_base = {i_mtvec.f.base, 2'b00};
    assign w_offs = {{(XLEN-CAUSE_W-2){1'b0}}, o_int_cause, 2'b00};

    assign o_int_tvec = (i_mtvec.f.mode == MTVEC_MODE_VECTORED) ? w_base + w_offs : w_base;

endmodule

/* rtl/trap_flow.sv */
// Trap, MRET and interrupt acceptance with the held trap-stage request
// One event at a time; new events wait until the held request is acked
// The execute-stage request is trusted to hold until ack by itself
module trap_flow (
    input  logic                          g_clk,
    input  logic                          i_arst_n,
    input  logic                          i_trap,
    input  logic [trap_pkg::CAUSE_W-1:0]  i_trap_cause,
    input  logic [trap_pkg::XLEN-1:0]     i_trap_pc,
    input  logic [trap_pkg::XLEN-1:0]     i_trap_mtval,
    input  logic                          i_mret,
    input  logic [trap_pkg::XLEN-1:0]     i_int_pc,
    input  logic                          i_int_request,
    input  logic [trap_pkg::CAUSE_W-1:0]  i_int_cause,
    input  logic [trap_pkg::XLEN-1:0]     i_int_tvec,
    input  trap_pkg::mtvec_word_u         i_mtvec,
    input  logic [trap_pkg::XLEN-1:0]     i_mepc,
    input  logic                          i_ex_cf_valid,
    input  logic [trap_pkg::XLEN-1:0]     i_ex_cf_target,
    input  logic                          i_cf_ack,
    output logic                          o_trap_take,   // CSR trap update strobe
    output logic                          o_trap_is_int,
    output logic [trap_pkg::CAUSE_W-1:0]  o_trap_cause,
    output logic [trap_pkg::XLEN-1:0]     o_trap_pc,
    output logic [trap_pkg::XLEN-1:0]     o_trap_mtval,
    output logic                          o_mret_take,   // CSR MRET update strobe
    output logic                          o_cf_valid,
    output logic [trap_pkg::XLEN-1:0]     o_cf_target,
    output logic                          o_ex_cancel,
    output logic                          o_ex_flush
);
    import trap_pkg::*;

    logic            held;                       // Trap-stage request live
    logic [XLEN-1:0] held_target;
    logic            w_take_cpu, w_take_mret, w_take_int;
    logic [XLEN-1:0] w_target_nxt;

    // ------------------------------------------------------------------
    // Acceptance, CPU trap over MRET over interrupt
    // ------------------------------------------------------------------
    assign w_take_cpu  = !held && i_trap;
    assign w_take_mret = !held && !i_trap && i_mret;
    assign w_take_int  = !held && !i_trap && !i_mret && i_int_request;

    assign o_trap_take   = w_take_cpu || w_take_int;
    assign o_trap_is_int = w_take_int;
    assign o_trap_cause  = w_take_int ? i_int_cause : i_trap_cause;
    assign o_trap_pc     = w_take_int ? i_int_pc    : i_trap_pc;
    assign o_trap_mtval  = w_take_int ? '0          : i_trap_mtval; // No value for irq
    assign o_mret_take   = w_take_mret;

    always_comb begin
        if (w_take_cpu) begin
            w_target_nxt = {i_mtvec.f.base, 2'b00}; // Exceptions never vector
        end else if (w_take_mret) begin
            w_target_nxt = i_mepc;               // mepc before any update
        end else begin
            w_target_nxt = i_int_tvec;
        end
    end

    always_ff @(posedge g_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            held <= 1'b0;
        end else if (held && i_cf_ack) begin
            held <= 1'b0;                        // Released on ack
        end else if (o_trap_take || w_take_mret) begin
            held <= 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!held) begin
            held_target <= w_target_nxt;         // Frozen while held
        end
    end

    // ------------------------------------------------------------------
    // Merge with execute, trap stage wins
    // ------------------------------------------------------------------
    assign o_cf_valid  = held || i_ex_cf_valid;
    assign o_cf_target = held ? held_target : i_ex_cf_target;
    assign o_ex_cancel = held;
    assign o_ex_flush  = held && i_cf_ack;

endmodule

/* rtl/trap_ctrl_top.sv */
// Machine-mode trap controller, CSRs plus interrupt and trap sequencing
// Only machine mode exists; CSR access ports are single-cycle strobes
module trap_ctrl_top (
    input  logic                           g_clk,
    input  logic                           i_arst_n,       // Async, active low
    input  logic                           i_int_sw,       // Software interrupt
    input  logic                           i_int_ext,      // External interrupt
    input  logic                           i_int_ti,       // Timer interrupt
    input  logic                           i_csr_en,       // CSR access strobe
    input  logic                           i_csr_wr,
    input  logic                           i_csr_set,
    input  logic                           i_csr_clr,
    input  logic [trap_pkg::CSR_ADDR_W-1:0] i_csr_addr,
    input  logic [trap_pkg::XLEN-1:0]      i_csr_wdata,
    output logic [trap_pkg::XLEN-1:0]      o_csr_rdata,
    output logic                           o_csr_error,    // Bad address or mip write
    input  logic                           i_trap,         // CPU trap strobe
    input  logic [trap_pkg::CAUSE_W-1:0]   i_trap_cause,
    input  logic [trap_pkg::XLEN-1:0]      i_trap_pc,
    input  logic [trap_pkg::XLEN-1:0]      i_trap_mtval,
    input  logic                           i_mret,         // MRET strobe
    input  logic [trap_pkg::XLEN-1:0]      i_int_pc,       // PC saved on interrupt
    input  logic                           i_ex_cf_valid,  // Execute-stage request
    input  logic [trap_pkg::XLEN-1:0]      i_ex_cf_target,
    input  logic                           i_cf_ack,
    output logic                           o_cf_valid,
    output logic [trap_pkg::XLEN-1:0]      o_cf_target,
    output logic                           o_ex_cancel,
    output logic                           o_ex_flush,
    output logic                           o_int_pending   // Enabled but masked by MIE
);
    import trap_pkg::*;

    // ------------------------------------------------------------------
    // CSR state to interrupt logic
    // ------------------------------------------------------------------
    logic              w_mstatus_mie;
    logic              w_mie_meie, w_mie_mtie, w_mie_msie;
    logic              w_mip_meip, w_mip_mtip, w_mip_msip;
    mtvec_word_u       w_mtvec;
    logic [XLEN-1:0]   w_mepc;

    logic              w_int_request;             // Enabled and unmasked
    logic [CAUSE_W-1:0] w_int_cause;
    logic [XLEN-1:0]   w_int_tvec;

    // Trap sequencing back into the CSRs
    logic              w_trap_take, w_trap_is_int, w_mret_take;
    logic [CAUSE_W-1:0] w_trap_cause;
    logic [XLEN-1:0]   w_trap_pc, w_trap_mtval;

    csr_regs u_csr_regs (
        .g_clk,
        .i_arst_n,
        .i_csr_en,
        .i_csr_wr,
        .i_csr_set,
        .i_csr_clr,
        .i_csr_addr,
        .i_csr_wdata,
        .o_csr_rdata,
        .o_csr_error,
        .i_int_sw,
        .i_int_ext,
        .i_int_ti,
        .i_trap_take   (w_trap_take),
        .i_trap_is_int (w_trap_is_int),
        .i_trap_cause  (w_trap_cause),
        .i_trap_pc     (w_trap_pc),
        .i_trap_mtval  (w_trap_mtval),
        .i_mret_take   (w_mret_take),
        .o_mstatus_mie (w_mstatus_mie),
        .o_mie_meie    (w_mie_meie),
        .o_mie_mtie    (w_mie_mtie),
        .o_mie_msie    (w_mie_msie),
        .o_mip_meip    (w_mip_meip),
        .o_mip_mtip    (w_mip_mtip),
        .o_mip_msip    (w_mip_msip),
        .o_mtvec       (w_mtvec),
        .o_mepc        (w_mepc)
    );

    int_prio u_int_prio (
        .i_mstatus_mie (w_mstatus_mie),
        .i_mie_meie    (w_mie_meie),
        .i_mie_mtie    (w_mie_mtie),
        .i_mie_msie    (w_mie_msie),
        .i_mip_meip    (w_mip_meip),
        .i_mip_mtip    (w_mip_mtip),
        .i_mip_msip    (w_mip_msip),
        .i_mtvec       (w_mtvec),
        .o_int_request (w_int_request),
        .o_int_cause   (w_int_cause),
        .o_int_tvec    (w_int_tvec),
        .o_int_pending
    );

    trap_flow u_trap_flow (
        .g_clk,
        .i_arst_n,
        .i_trap,
        .i_trap_cause,
        .i_trap_pc,
        .i_trap_mtval,
        .i_mret,
        .i_int_pc,
        .i_int_request (w_int_request),
        .i_int_cause   (w_int_cause),
        .i_int_tvec    (w_int_tvec),
        .i_mtvec       (w_mtvec),
        .i_mepc        (w_mepc),
        .i_ex_cf_valid,
        .i_ex_cf_target,
        .i_cf_ack,
        .o_trap_take   (w_trap_take),
        .o_trap_is_int (w_trap_is_int),
        .o_trap_cause  (w_trap_cause),
        .o_trap_pc     (w_trap_pc),
        .o_trap_mtval  (w_trap_mtval),
        .o_mret_take   (w_mret_take),
        .o_cf_valid,
        .o_cf_target,
        .o_ex_cancel,
        .o_ex_flush
    );

endmodule

/* verification/tb_trap_ctrl.sv */
// Testbench for trap_ctrl_top with a cycle-level model of the machine CSRs
// Concurrent assertions compare the DUT against the model on every edge
// Stimulus never overlaps a CSR write with a trap in the same cycle
module tb_trap_ctrl;
    timeunit 1ns;
    timeprecision 100ps;
    import trap_pkg::*;

    localparam logic [31:0] SEED       = 32'h9d54437e;
    localparam int          CF_TIMEOUT = 50;              // Cycles per wait
    localparam logic [1:0]  OP_RD = 2'd0, OP_WR = 2'd1, OP_SET = 2'd2, OP_CLR = 2'd3;
    localparam logic [31:0] ST_MASK = (32'h1 << MSTATUS_MIE_BIT) | (32'h1 << MSTATUS_MPIE_BIT);
    localparam logic [31:0] IE_MASK = (32'h1 << IRQ_MEI) | (32'h1 << IRQ_MTI) | (32'h1 << IRQ_MSI);

    logic g_clk, i_arst_n;
    logic i_int_sw, i_int_ext, i_int_ti;
    logic i_csr_en, i_csr_wr, i_csr_set, i_csr_clr;
    logic [CSR_ADDR_W-1:0] i_csr_addr;
    logic [XLEN-1:0] i_csr_wdata, o_csr_rdata;
    logic o_csr_error;
    logic i_trap, i_mret;
    logic [CAUSE_W-1:0] i_trap_cause;
    logic [XLEN-1:0] i_trap_pc, i_trap_mtval, i_int_pc;
    logic i_ex_cf_valid, i_cf_ack;
    logic [XLEN-1:0] i_ex_cf_target, o_cf_target;
    logic o_cf_valid, o_ex_cancel, o_ex_flush, o_int_pending;

    int errors   = 0;
    int timeouts = 0;

    trap_ctrl_top uut (.*);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;                         // 4 ns period
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    logic [31:0] m_mstatus, m_mie, m_mip, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval;
    logic        m_held;                                   // Trap-stage request live
    logic [31:0] m_target;
    logic [31:0] m_rd, m_wval, m_enabled, m_vec;
    logic        m_known, m_err, m_req, m_mie_on;
    logic [4:0]  m_cause;

    always_comb begin
        m_known = 1'b1;
        case (i_csr_addr)
            CSR_MSTATUS:  m_rd = m_mstatus;
            CSR_MIE:      m_rd = m_mie;
            CSR_MTVEC:    m_rd = m_mtvec;
            CSR_MSCRATCH: m_rd = m_mscratch;
            CSR_MEPC:     m_rd = m_mepc;
            CSR_MCAUSE:   m_rd = m_mcause;
            CSR_MTVAL:    m_rd = m_mtval;
            CSR_MIP:      m_rd = m_mip;
            default: begin
                m_rd    = '0;
                m_known = 1'b0;
            end
        endcase
        m_wval = i_csr_wr ? i_csr_wdata : i_csr_set ? (m_rd | i_csr_wdata) : (m_rd & ~i_csr_wdata);
        m_err  = i_csr_en && (!m_known ||
                 ((i_csr_wr || i_csr_set || i_csr_clr) && i_csr_addr == CSR_MIP));
        m_enabled = m_mip & m_mie;
        m_mie_on  = m_mstatus[MSTATUS_MIE_BIT];
        m_req     = (m_enabled != 0) && m_mie_on;
        m_cause   = m_enabled[IRQ_MEI] ? IRQ_MEI : m_enabled[IRQ_MSI] ? IRQ_MSI : IRQ_MTI;
        m_vec     = {m_mtvec[31:2], 2'b00};                // Direct mode target
        if (m_mtvec[1:0] == MTVEC_MODE_VECTORED) begin
            m_vec = m_vec + (32'(m_cause) << 2);
        end
    end

    always @(posedge g_clk or negedge i_arst_n) begin : model_update
        logic take_cpu, take_mret, take_int, wr;
        if (!i_arst_n) begin
            m_mstatus  <= '0;
            m_mie      <= '0;
            m_mip      <= '0;
            m_mtvec    <= MTVEC_RESET;
            m_mscratch <= '0;
            m_mepc     <= '0;
            m_mcause   <= '0;
            m_mtval    <= '0;
            m_held     <= 1'b0;
            m_target   <= '0;
        end else begin
            take_cpu  = !m_held && i_trap;
            take_mret = !m_held && !i_trap && i_mret;
            take_int  = !m_held && !i_trap && !i_mret && m_req;
            wr        = i_csr_en && (i_csr_wr || i_csr_set || i_csr_clr);
            m_mip <= (32'(i_int_ext) << IRQ_MEI) | (32'(i_int_ti) << IRQ_MTI)
                   | (32'(i_int_sw) << IRQ_MSI);          // One cycle late
            if (wr) begin
                case (i_csr_addr)
                    CSR_MSTATUS:  m_mstatus  <= m_wval & ST_MASK;
                    CSR_MIE:      m_mie      <= m_wval & IE_MASK;
                    CSR_MTVEC:    m_mtvec    <= m_wval & ~32'h2; // Mode bit 1 stuck low
                    CSR_MSCRATCH: m_mscratch <= m_wval;
                    CSR_MEPC:     m_mepc     <= m_wval & ~32'h3;
                    CSR_MCAUSE:   m_mcause   <= m_wval;
                    CSR_MTVAL:    m_mtval    <= m_wval;
                    default:      ;
                endcase
            end
            // Later assignments override a same-cycle write
            if (take_cpu || take_int) begin
                m_mstatus <= 32'(m_mie_on) << MSTATUS_MPIE_BIT;
                m_mepc    <= (take_int ? i_int_pc : i_trap_pc) & ~32'h3;
                m_mcause  <= {take_int, 26'd0, take_int ? m_cause : i_trap_cause};
                m_mtval   <= take_int ? '0 : i_trap_mtval;
            end else if (take_mret) begin
                m_mstatus <= (32'(m_mstatus[MSTATUS_MPIE_BIT]) << MSTATUS_MIE_BIT)
                           | (32'h1 << MSTATUS_MPIE_BIT);
            end
            if (m_held && i_cf_ack) begin
                m_held <= 1'b0;
            end else if (take_cpu || take_mret || take_int) begin
                m_held   <= 1'b1;
                m_target <= take_cpu ? {m_mtvec[31:2], 2'b00} : take_mret ? m_mepc : m_vec;
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_rdata: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        i_csr_en && m_known |-> o_csr_rdata == m_rd)
        else begin
            errors++;
            $display("** Error: o_csr_rdata = %h, expected %h (addr %h)",
                     $sampled(o_csr_rdata), $sampled(m_rd), $sampled(i_csr_addr));
        end

    a_error: assert property (@(posedge g_clk) disable iff (!i_arst_n) o_csr_error == m_err)
        else begin
            errors++;
            $display("** Error: o_csr_error = %h, expected %h (addr %h)",
                     $sampled(o_csr_error), $sampled(m_err), $sampled(i_csr_addr));
        end

    a_cf_valid: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        o_cf_valid == (m_held || i_ex_cf_valid))
        else begin
            errors++;
            $display("** Error: o_cf_valid = %h, expected %h",
                     $sampled(o_cf_valid), $sampled(m_held || i_ex_cf_valid));
        end

    a_cf_target: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        o_cf_valid |-> o_cf_target == (m_held ? m_target : i_ex_cf_target))
        else begin
            errors++;
            $display("** Error: o_cf_target = %h, expected %h", $sampled(o_cf_target),
                     $sampled(m_held ? m_target : i_ex_cf_target));
        end

    a_cancel: assert property (@(posedge g_clk) disable iff (!i_arst_n) o_ex_cancel == m_held)
        else begin
            errors++;
            $display("** Error: o_ex_cancel = %h, expected %h",
                     $sampled(o_ex_cancel), $sampled(m_held));
        end

    a_flush: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        o_ex_flush == (m_held && i_cf_ack))
        else begin
            errors++;
            $display("** Error: o_ex_flush = %h, expected %h",
                     $sampled(o_ex_flush), $sampled(m_held && i_cf_ack));
        end

    a_pending: assert property (@(posedge g_clk) disable iff (!i_arst_n)
        o_int_pending == ((m_enabled != 0) && !m_mie_on))
        else begin
            errors++;
            $display("** Error: o_int_pending = %h, expected %h",
                     $sampled(o_int_pending), $sampled((m_enabled != 0) && !m_mie_on));
        end

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------
    task automatic csr_op(input logic [1:0] op, input logic [11:0] addr, input logic [31:0] data);
        @(posedge g_clk);
        i_csr_en    <= 1'b1;
        i_csr_wr    <= (op == OP_WR);
        i_csr_set   <= (op == OP_SET);
        i_csr_clr   <= (op == OP_CLR);
        i_csr_addr  <= addr;
        i_csr_wdata <= data;
        @(posedge g_clk);
        i_csr_en  <= 1'b0;
        i_csr_wr  <= 1'b0;
        i_csr_set <= 1'b0;
        i_csr_clr <= 1'b0;
    endtask

    task automatic read_all();
        csr_op(OP_RD, CSR_MSTATUS, '0);
        csr_op(OP_RD, CSR_MIE, '0);
        csr_op(OP_RD, CSR_MTVEC, '0);
        csr_op(OP_RD, CSR_MSCRATCH, '0);
        csr_op(OP_RD, CSR_MEPC, '0);
        csr_op(OP_RD, CSR_MCAUSE, '0);
        csr_op(OP_RD, CSR_MTVAL, '0);
        csr_op(OP_RD, CSR_MIP, '0);
    endtask

    task automatic cpu_trap(input logic [4:0] cause, input logic [31:0] pc, input logic [31:0] tval);
        @(posedge g_clk);
        i_trap       <= 1'b1;
        i_trap_cause <= cause;
        i_trap_pc    <= pc;
        i_trap_mtval <= tval;
        @(posedge g_clk);
        i_trap <= 1'b0;
    endtask

    task automatic mret_strobe();
        @(posedge g_clk);
        i_mret <= 1'b1;
        @(posedge g_clk);
        i_mret <= 1'b0;
    endtask

    // Wait for a request, keep it waiting a few cycles, then ack it
    task automatic ack_request();
        int n;
        int hold;
        n    = 0;
        hold = $urandom_range(3, 0);
        @(negedge g_clk);
        while (!o_cf_valid && n < CF_TIMEOUT) begin
            @(negedge g_clk);
            n++;
        end
        if (!o_cf_valid) begin
            timeouts++;
            $display("Timeout: o_cf_valid did not rise within %0d cycles", CF_TIMEOUT);
        end else begin
            repeat (hold) @(posedge g_clk);
            @(posedge g_clk);
            i_cf_ack <= 1'b1;
            @(posedge g_clk);
            i_cf_ack <= 1'b0;
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        i_arst_n = 1'b0;
        {i_int_sw, i_int_ext, i_int_ti} = '0;
        {i_csr_en, i_csr_wr, i_csr_set, i_csr_clr} = '0;
        i_csr_addr = '0;
        i_csr_wdata = '0;
        {i_trap, i_mret, i_ex_cf_valid, i_cf_ack} = '0;
        i_trap_cause = '0;
        i_trap_pc = '0;
        i_trap_mtval = '0;
        i_int_pc = '0;
        i_ex_cf_target = '0;
        repeat (10) @(posedge g_clk);
        i_arst_n <= 1'b1;

        read_all();                                        // Reset values
        csr_op(OP_RD, 12'h7c0, '0);                        // Unknown address
        csr_op(OP_WR, CSR_MSCRATCH, $urandom());
        csr_op(OP_SET, CSR_MSCRATCH, $urandom());
        csr_op(OP_CLR, CSR_MSCRATCH, $urandom());
        csr_op(OP_RD, CSR_MSCRATCH, '0);
        csr_op(OP_WR, CSR_MIP, IE_MASK);                   // mip is read only
        csr_op(OP_SET, CSR_MIP, 32'h8);

        csr_op(OP_WR, CSR_MSTATUS, 32'h8);                 // MIE on
        csr_op(OP_WR, CSR_MTVEC, $urandom());
        cpu_trap(5'd2, $urandom(), $urandom());
        ack_request();
        read_all();
        mret_strobe();
        ack_request();
        csr_op(OP_RD, CSR_MSTATUS, '0);

        csr_op(OP_WR, CSR_MIE, IE_MASK);
        csr_op(OP_WR, CSR_MTVEC, ($urandom() & ~32'h3) | 32'h1); // Vectored
        @(posedge g_clk);
        i_int_pc  <= $urandom() & ~32'h3;
        i_int_ext <= 1'b1;
        i_int_sw  <= 1'b1;
        i_int_ti  <= 1'b1;
        ack_request();                                     // External first
        csr_op(OP_RD, CSR_MCAUSE, '0);
        csr_op(OP_RD, CSR_MEPC, '0);
        @(posedge g_clk);
        i_int_ext <= 1'b0;
        mret_strobe();
        ack_request();
        ack_request();                                     // Then software
        @(posedge g_clk);
        i_int_sw <= 1'b0;
        mret_strobe();
        ack_request();
        ack_request();                                     // Then timer
        @(posedge g_clk);
        i_int_ti <= 1'b0;
        mret_strobe();
        ack_request();

        @(posedge g_clk);
        i_ex_cf_valid  <= 1'b1;                            // Execute request alone
        i_ex_cf_target <= $urandom();
        ack_request();
        i_ex_cf_valid <= 1'b0;
        @(posedge g_clk);
        i_ex_cf_valid  <= 1'b1;                            // Both at once
        i_ex_cf_target <= $urandom();
        i_trap         <= 1'b1;
        i_trap_cause   <= 5'd11;
        i_trap_pc      <= $urandom();
        i_trap_mtval   <= $urandom();
        @(posedge g_clk);
        i_trap <= 1'b0;
        ack_request();
        i_ex_cf_valid <= 1'b0;

        csr_op(OP_WR, CSR_MSTATUS, '0);                    // Masked interrupt
        @(posedge g_clk);
        i_int_ti <= 1'b1;
        csr_op(OP_RD, CSR_MIP, '0);
        csr_op(OP_RD, CSR_MIP, '0);
        i_int_ti <= 1'b0;
        repeat (4) @(posedge g_clk);

        $display("Run complete: %0d assertion errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* trap_ctrl.f */
common/trap_pkg.sv
csr/csr_regs.sv
csr/int_prio.sv
rtl/trap_flow.sv
rtl/trap_ctrl_top.sv
verification/tb_trap_ctrl.sv

/* Bender.yml */
package:
  name: trap_ctrl

sources:
  - files:
      - common/trap_pkg.sv
      - csr/csr_regs.sv
      - csr/int_prio.sv
      - rtl/trap_flow.sv
      - rtl/trap_ctrl_top.sv
  - target: test
    files:
      - verification/tb_trap_ctrl.sv
